//--- motorPkg.sv
package motorPkg;

    // commutation
    localparam int stepCount  = 12;
    localparam int stepIndexW = 4;

    // pwm timing widths
    localparam int periodW   = 12;
    localparam int onLenW    = 16;
    localparam int fracW     = 4;
    localparam int stepLenW  = 16;
    localparam int deadTimeW = 3;

    // register map
    localparam int regAddrW = 2;
    localparam logic [regAddrW-1:0] addrTiming = 2'd0;
    localparam logic [regAddrW-1:0] addrDrive  = 2'd1;

    // layout of a write to addrTiming
    typedef struct packed {
        logic                 enable;
        logic [deadTimeW-1:0] deadTime;
        logic [periodW-1:0]   pwmMin;
        logic [periodW-1:0]   pwmLenWant;
        logic [3:0]           spare;
    } cfgTimingT;

    // layout of a write to addrDrive
    // onLen is whole cycles in the upper bits, sixteenths in the low fracW bits
    typedef struct packed {
        logic [onLenW-1:0]   onLen;
        logic [stepLenW-1:0] stepLen;
    } cfgDriveT;

    // one write word, read through the view the address selects
    typedef union packed {
        cfgTimingT timing;
        cfgDriveT  drive;
    } cfgWordT;

    // drive role of one phase in one step
    typedef enum logic [1:0] {
        roleHigh,
        roleLow,
        roleFloat
    } phaseRoleT;

    // roles per phase and step, B and C are A rotated by four and eight steps
    localparam phaseRoleT commTable [3][stepCount] = '{
        // phase A
        '{roleHigh,  roleHigh,  roleHigh,  roleHigh,  roleFloat, roleFloat,
          roleLow,   roleLow,   roleLow,   roleLow,   roleFloat, roleFloat},
        // phase B
        '{roleLow,   roleLow,   roleFloat, roleFloat, roleHigh,  roleHigh,
          roleHigh,  roleHigh,  roleFloat, roleFloat, roleLow,   roleLow},
        // phase C
        '{roleFloat, roleFloat, roleLow,   roleLow,   roleLow,   roleLow,
          roleFloat, roleFloat, roleHigh,  roleHigh,  roleHigh,  roleHigh}
    };

endpackage

//--- motorRegs.sv
`timescale 1ns/1ps

module motorRegs (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           regWr,
    input  logic [motorPkg::regAddrW-1:0]  regAddr,
    input  motorPkg::cfgWordT              regData,
    output logic                           enable,
    output logic [motorPkg::deadTimeW-1:0] deadTime,
    output logic [motorPkg::periodW-1:0]   pwmMin,
    output logic [motorPkg::periodW-1:0]   pwmLenWant,
    output logic [motorPkg::onLenW-1:0]    onLen,
    output logic [motorPkg::stepLenW-1:0]  stepLen
);

    import motorPkg::*;

    logic wrTiming;
    logic wrDrive;

    assign wrTiming = regWr && (regAddr == addrTiming);
    assign wrDrive  = regWr && (regAddr == addrDrive);

    // timing fields, enable lives here so a single write can start the drive
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            enable     <= 1'b0;
            deadTime   <= '0;
            pwmMin     <= '0;
            pwmLenWant <= '0;
        end else if (wrTiming) begin
            enable     <= regData.timing.enable;
            deadTime   <= regData.timing.deadTime;
            pwmMin     <= regData.timing.pwmMin;
            pwmLenWant <= regData.timing.pwmLenWant;
        end
    end

    // drive fields
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            onLen   <= '0;
            stepLen <= '0;
        end else if (wrDrive) begin
            onLen   <= regData.drive.onLen;
            stepLen <= regData.drive.stepLen;
        end
    end

    // writes to unmapped addresses would be silently lost
    addrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        regWr |-> (regAddr == addrTiming) || (regAddr == addrDrive)
    ) else $error("write to unmapped register address %0d", regAddr);

endmodule

//--- stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            enable,
    input  logic [motorPkg::stepLenW-1:0]   stepLen,
    output logic [motorPkg::stepIndexW-1:0] stepIndex,
    output logic                            stepFirst,
    output logic                            stepLast
);

    import motorPkg::*;

    // cycles left in the current step
    // zero marks the first cycle
    logic [stepLenW-1:0] stepCnt;
    logic                indexWrap;

    assign stepFirst = enable && (stepCnt == '0);
    assign stepLast  = enable && (stepCnt == stepLenW'(1));
    assign indexWrap = (stepIndex == stepIndexW'(stepCount - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepCnt <= '0;
        end else if (!enable) begin
            stepCnt <= '0;
        end else if (stepFirst) begin
            // the first cycle is already spent
            stepCnt <= stepLen - 1'b1;
        end else begin
            stepCnt <= stepCnt - 1'b1;
        end
    end

    // index moves on the edge after the last cycle of a step
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepIndex <= '0;
        end else if (!enable) begin
            stepIndex <= '0;
        end else if (stepLast) begin
            if (indexWrap) begin
                stepIndex <= '0;
            end else begin
                stepIndex <= stepIndex + 1'b1;
            end
        end
    end

    indexRange: assert property (
        @(posedge clk) disable iff (!arstN)
        stepIndex <= stepIndexW'(stepCount - 1)
    ) else $error("step index %0d out of range", stepIndex);

    // holds as long as every step is at least two cycles long
    strobeExclusive: assert property (
        @(posedge clk) disable iff (!arstN)
        !(stepFirst && stepLast)
    ) else $error("step first and last strobes coincide");

endmodule

//--- pwmPhaseGen.sv
`timescale 1ns/1ps

module pwmPhaseGen #(
    parameter int phaseIdx = 0
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            enable,
    input  logic [motorPkg::periodW-1:0]    pwmLenWant,
    input  logic [motorPkg::periodW-1:0]    pwmMin,
    input  logic [motorPkg::onLenW-1:0]     onLen,
    input  logic [motorPkg::stepIndexW-1:0] stepIndex,
    input  logic                            stepFirst,
    input  logic                            stepLast,
    output logic                            pwm,
    output motorPkg::phaseRoleT             role
);

    import motorPkg::*;

    logic [periodW-1:0] periodCnt;
    logic [periodW-1:0] pulseCnt;
    logic [periodW-1:0] lenLimit;
    logic [periodW-1:0] pulseLen;
    logic [periodW:0]   wholeSum;
    logic [onLenW:0]    accSum;
    logic [onLenW-1:0]  acc;
    logic [onLenW-1:0]  accKeep;
    logic [onLenW-1:0]  accNext;
    logic               periodReload;
    logic               emit;

    assign role = commTable[phaseIdx][stepIndex];

    // a new period starts with every step, otherwise when the counter runs out
    // no period starts in the last step cycle since the step start reloads anyway
    assign periodReload = enable && (stepFirst || (periodCnt == '0 && !stepLast));
    assign lenLimit     = pwmLenWant - 1'b1;

    // remainder plus the requested on-length, one extra bit for withheld pulses
    assign accSum   = {1'b0, acc} + {1'b0, onLen};
    assign wholeSum = accSum[onLenW:fracW];

    // whole part capped so the gate always drops once per period
    always_comb begin
        if (wholeSum > {1'b0, lenLimit}) begin
            pulseLen = lenLimit;
        end else begin
            pulseLen = wholeSum[periodW-1:0];
        end
    end

    // short pulses are withheld and their whole part kept for later periods
    assign emit = (pulseLen != '0) && (pulseLen >= pwmMin);

    // saturate instead of wrapping when a bad setting keeps withholding
    assign accKeep = accSum[onLenW] ? '1 : accSum[onLenW-1:0];

    always_comb begin
        if (emit) begin
            accNext = {{(onLenW - fracW){1'b0}}, accSum[fracW-1:0]};
        end else begin
            accNext = accKeep;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
        end else if (!enable) begin
            periodCnt <= '0;
        end else if (periodReload) begin
            periodCnt <= lenLimit;
        end else if (periodCnt != '0) begin
            periodCnt <= periodCnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            acc <= '0;
        end else if (!enable) begin
            acc <= '0;
        end else if (periodReload) begin
            acc <= accNext;
        end
    end

    // a pulse cut by a step start either merges with the new one or runs out
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pulseCnt <= '0;
        end else if (!enable) begin
            pulseCnt <= '0;
        end else if (periodReload && emit) begin
            pulseCnt <= pulseLen;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = (pulseCnt != '0);

    // every pulse starts with enough cycles loaded to reach the minimum
    minPulse: assert property (
        @(posedge clk) disable iff (!arstN || !enable)
        $rose(pwm) |-> pulseCnt >= pwmMin
    ) else $error("phase %0d pulse of %0d below minimum %0d", phaseIdx, pulseCnt, pwmMin);

endmodule

//--- gateDeadtime.sv
`timescale 1ns/1ps

module gateDeadtime (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [motorPkg::deadTimeW-1:0] deadTime,
    input  logic                           pwm,
    input  motorPkg::phaseRoleT            role,
    output logic                           gateHi,
    output logic                           gateLo
);

    import motorPkg::*;

    logic                 reqHi;
    logic                 reqLo;
    logic                 holdHi;
    logic                 holdLo;
    logic                 hiNext;
    logic                 loNext;
    logic [deadTimeW-1:0] deadCnt;
    logic                 lastOffHi;

    // the active side follows pwm, a floating phase requests nothing
    assign reqHi = pwm && (role == roleHigh);
    assign reqLo = pwm && (role == roleLow);

    // a side waits while the other is on or its dead time is still running
    assign holdHi = gateLo || ((deadCnt != '0) && !lastOffHi);
    assign holdLo = gateHi || ((deadCnt != '0) && lastOffHi);

    assign hiNext = reqHi && !holdHi;
    assign loNext = reqLo && !holdLo;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            gateHi    <= 1'b0;
            gateLo    <= 1'b0;
            deadCnt   <= '0;
            lastOffHi <= 1'b0;
        end else begin
            gateHi <= hiNext;
            gateLo <= loNext;
            // dead time restarts at each falling gate
            if (gateHi && !hiNext) begin
                deadCnt   <= deadTime;
                lastOffHi <= 1'b1;
            end else if (gateLo && !loNext) begin
                deadCnt   <= deadTime;
                lastOffHi <= 1'b0;
            end else if (deadCnt != '0) begin
                deadCnt <= deadCnt - 1'b1;
            end
        end
    end

    noShootThrough: assert property (
        @(posedge clk) disable iff (!arstN)
        !(gateHi && gateLo)
    ) else $error("high and low gate on together");

endmodule

//--- motorDriveTop.sv
`timescale 1ns/1ps

module motorDriveTop (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            regWr,
    input  logic [motorPkg::regAddrW-1:0]   regAddr,
    input  motorPkg::cfgWordT               regData,
    output logic [motorPkg::stepIndexW-1:0] stepIndex,
    output logic                            gateHiA,
    output logic                            gateLoA,
    output logic                            gateHiB,
    output logic                            gateLoB,
    output logic                            gateHiC,
    output logic                            gateLoC
);

    import motorPkg::*;

    logic                 enable;
    logic [deadTimeW-1:0] deadTime;
    logic [periodW-1:0]   pwmMin;
    logic [periodW-1:0]   pwmLenWant;
    logic [onLenW-1:0]    onLen;
    logic [stepLenW-1:0]  stepLen;
    logic                 stepFirst;
    logic                 stepLast;
    logic [2:0]           pwm;
    logic [2:0]           gateHi;
    logic [2:0]           gateLo;
    phaseRoleT            role [3];

    motorRegs motorRegs_inst (
        .clk        (clk),
        .arstN      (arstN),
        .regWr      (regWr),
        .regAddr    (regAddr),
        .regData    (regData),
        .enable     (enable),
        .deadTime   (deadTime),
        .pwmMin     (pwmMin),
        .pwmLenWant (pwmLenWant),
        .onLen      (onLen),
        .stepLen    (stepLen)
    );

    stepSequencer stepSequencer_inst (
        .clk       (clk),
        .arstN     (arstN),
        .enable    (enable),
        .stepLen   (stepLen),
        .stepIndex (stepIndex),
        .stepFirst (stepFirst),
        .stepLast  (stepLast)
    );

    // index 0, 1 and 2 are phases A, B and C
    for (genvar p = 0; p < 3; p++) begin : gPhase
        pwmPhaseGen #(
            .phaseIdx (p)
        ) pwmPhaseGen_inst (
            .clk        (clk),
            .arstN      (arstN),
            .enable     (enable),
            .pwmLenWant (pwmLenWant),
            .pwmMin     (pwmMin),
            .onLen      (onLen),
            .stepIndex  (stepIndex),
            .stepFirst  (stepFirst),
            .stepLast   (stepLast),
            .pwm        (pwm[p]),
            .role       (role[p])
        );

        gateDeadtime gateDeadtime_inst (
            .clk      (clk),
            .arstN    (arstN),
            .deadTime (deadTime),
            .pwm      (pwm[p]),
            .role     (role[p]),
            .gateHi   (gateHi[p]),
            .gateLo   (gateLo[p])
        );
    end

    assign gateHiA = gateHi[0];
    assign gateLoA = gateLo[0];
    assign gateHiB = gateHi[1];
    assign gateLoB = gateLo[1];
    assign gateHiC = gateHi[2];
    assign gateLoC = gateLo[2];

endmodule

//--- motorDriveTb.sv
`timescale 1ns/1ps

module motorDriveTb;

    import motorPkg::*;

    localparam int commStepLen = 20;
    localparam int deadTimeSet = 7;
    // reset, five restarts of 13 cycles, then the window of each test
    localparam int totalCycles = 16 + 5 * 13 + 13 * commStepLen + 256 + 2 * 160 + 96;
    localparam int watchdogNs  = totalCycles * 8 * 3 / 2;

    logic                  clk;
    logic                  arstN;
    logic                  regWr;
    logic [regAddrW-1:0]   regAddr;
    cfgWordT               regData;
    logic [stepIndexW-1:0] stepIndex;
    logic [2:0]            gateHi;
    logic [2:0]            gateLo;

    motorDriveTop motorDriveTop_inst (
        .clk       (clk),
        .arstN     (arstN),
        .regWr     (regWr),
        .regAddr   (regAddr),
        .regData   (regData),
        .stepIndex (stepIndex),
        .gateHiA   (gateHi[0]),
        .gateLoA   (gateLo[0]),
        .gateHiB   (gateHi[1]),
        .gateLoB   (gateLo[1]),
        .gateHiC   (gateHi[2]),
        .gateLoC   (gateLo[2])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired after %0d ns before the tests finished", watchdogNs);
        abortRun();
    end

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkStep(input string name, input logic [stepIndexW-1:0] expected,
                             input logic [stepIndexW-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t %s expected %0d actual %0d", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkGate(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL at %0t %s expected %b actual %b", $time, name, expected, actual);
            abortRun();
        end
    endtask

    // counts are allowed to fall anywhere inside lo to hi
    task automatic checkCount(input string name, input int lo, input int hi, input int actual);
        if (actual < lo || actual > hi) begin
            $display("FAIL at %0t %s expected %0d to %0d actual %0d",
                     $time, name, lo, hi, actual);
            abortRun();
        end
    endtask

    task automatic writeReg(input logic [regAddrW-1:0] addr, input cfgWordT word);
        regWr   = 1'b1;
        regAddr = addr;
        regData = word;
        @(negedge clk);
        regWr = 1'b0;
    endtask

    // returns in the first enabled cycle, which is the first cycle of step 0
    task automatic startDrive(input int dead, input int pmin, input int plen, input int onl,
                              input int slen);
        cfgWordT word;
        word = '0;
        writeReg(addrTiming, word);
        repeat (10) @(negedge clk);
        word.drive.onLen   = onLenW'(onl);
        word.drive.stepLen = stepLenW'(slen);
        writeReg(addrDrive, word);
        word = '0;
        word.timing.enable     = 1'b1;
        word.timing.deadTime   = deadTimeW'(dead);
        word.timing.pwmMin     = periodW'(pmin);
        word.timing.pwmLenWant = periodW'(plen);
        writeReg(addrTiming, word);
    endtask

    // phase A is high in steps 0 to 3 and low in steps 6 to 9
    // phases B and C follow four and eight steps later
    function automatic phaseRoleT expRole(input int phase, input int step);
        int s;
        s = (step + stepCount - 4 * phase) % stepCount;
        if (s < 4) begin
            return roleHigh;
        end else if (s >= 6 && s < 10) begin
            return roleLow;
        end
        return roleFloat;
    endfunction

    // high cycles, finished pulses and shortest pulse of the phase A high gate
    task automatic measurePulses(input int cycles, output int total, output int runs,
                                 output int shortest);
        int run;
        total    = 0;
        runs     = 0;
        shortest = cycles;
        run      = 0;
        repeat (cycles) begin
            if (gateHi[0]) begin
                run++;
                total++;
            end else if (run > 0) begin
                runs++;
                shortest = (run < shortest) ? run : shortest;
                run = 0;
            end
            @(negedge clk);
        end
    endtask

    task automatic testReset();
        repeat (5) @(negedge clk);
        checkStep("stepIndex", '0, stepIndex);
        checkGate("any gateHi", 1'b0, |gateHi);
        checkGate("any gateLo", 1'b0, |gateLo);
    endtask

    task automatic testCommutation();
        int cyc;
        int p;
        int prev;
        phaseRoleT r;
        startDrive(1, 2, 10, 4 << fracW, commStepLen);
        // thirteen steps so the index wraps once
        for (cyc = 0; cyc < 13 * commStepLen; cyc++) begin
            checkStep("stepIndex", stepIndexW'((cyc / commStepLen) % stepCount), stepIndex);
            // gates show the role of the previous cycle
            prev = (cyc == 0) ? 0 : ((cyc - 1) / commStepLen) % stepCount;
            for (p = 0; p < 3; p++) begin
                r = expRole(p, prev);
                if (r != roleHigh) begin
                    checkGate($sformatf("gateHi[%0d]", p), 1'b0, gateHi[p]);
                end
                if (r != roleLow) begin
                    checkGate($sformatf("gateLo[%0d]", p), 1'b0, gateLo[p]);
                end
            end
            @(negedge clk);
        end
    endtask

    task automatic testWholeOnLen();
        int total, runs, shortest;
        // five cycles in each of the sixteen periods of steps 0 to 3
        startDrive(2, 2, 16, 5 << fracW, 64);
        measurePulses(256, total, runs, shortest);
        checkCount("gateHiA pulses", 16, 16, runs);
        checkCount("gateHiA shortest pulse", 5, 5, shortest);
        checkCount("gateHiA high cycles", 80, 80, total);
    endtask

    // average duty over the ten periods of step 0 with a random fraction
    task automatic testAverageDuty(input int whole, input int pmin, input int tol);
        int onl, expTotal, total, runs, shortest;
        onl = (whole << fracW) | (1 + $urandom % 15);
        startDrive(2, pmin, 16, onl, 160);
        measurePulses(160, total, runs, shortest);
        expTotal = (10 * onl) >> fracW;
        checkCount("gateHiA pulses", 1, 10, runs);
        checkCount("gateHiA shortest pulse", pmin, 15, shortest);
        checkCount("gateHiA high cycles", expTotal - tol, expTotal + tol, total);
    endtask

    task automatic testDeadTime();
        int cyc, p, gaps;
        int offCyc [3];
        int offHi [3];
        logic [2:0] prevHi;
        logic [2:0] prevLo;
        gaps   = 0;
        offCyc = '{0, 0, 0};
        offHi  = '{2, 2, 2};
        prevHi = '0;
        prevLo = '0;
        // pwm stays on so each phase crosses between its sides through two float steps
        startDrive(deadTimeSet, 1, 16, 3 << fracW, 2);
        for (cyc = 0; cyc < 96; cyc++) begin
            checkGate("gateHi and gateLo together", 1'b0, |(gateHi & gateLo));
            for (p = 0; p < 3; p++) begin
                if (prevHi[p] && !gateHi[p]) begin
                    offCyc[p] = cyc;
                    offHi[p]  = 1;
                end
                if (prevLo[p] && !gateLo[p]) begin
                    offCyc[p] = cyc;
                    offHi[p]  = 0;
                end
                if ((!prevLo[p] && gateLo[p] && offHi[p] == 1) ||
                    (!prevHi[p] && gateHi[p] && offHi[p] == 0)) begin
                    checkCount($sformatf("dead gap phase %0d", p), deadTimeSet, 96,
                               cyc - offCyc[p]);
                    gaps++;
                end
            end
            prevHi = gateHi;
            prevLo = gateLo;
            @(negedge clk);
        end
        checkCount("side changes seen", 8, 96, gaps);
    endtask

    initial begin
        void'($urandom(32'h22f2));
        arstN   = 1'b0;
        regWr   = 1'b0;
        regAddr = '0;
        regData = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        testReset();
        testCommutation();
        testWholeOnLen();
        testAverageDuty(6, 2, 1);
        // whole part below the minimum, withheld pulses make up the rest later
        testAverageDuty(2, 6, 6);
        testDeadTime();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- project.f
motorPkg.sv
motorRegs.sv
stepSequencer.sv
pwmPhaseGen.sv
gateDeadtime.sv
motorDriveTop.sv
motorDriveTb.sv

//--- Bender.yml
package:
  name: motor_drive

sources:
  - motorPkg.sv
  - motorRegs.sv
  - stepSequencer.sv
  - pwmPhaseGen.sv
  - gateDeadtime.sv
  - motorDriveTop.sv
  - target: test
    files:
      - motorDriveTb.sv
